// File: rtl/cpu_pkg.sv
package cpu_pkg;

    //////////////////////////////////////////////////
    // Basic types
    //////////////////////////////////////////////////

    typedef logic [15:0] word_t;
    typedef logic [1:0]  reg_idx_t;
    typedef logic [3:0]  opcode_t;
    typedef logic [5:0]  funct_t;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_LHI,
        ALU_PASS_B
    } alu_op_t;

    // Execute operand source
    typedef enum logic [1:0] {
        FWD_NONE,
        FWD_FROM_MEM,
        FWD_FROM_WB
    } fwd_sel_t;

    //////////////////////////////////////////////////
    // Instruction format
    //////////////////////////////////////////////////

    localparam int OPCODE_HI = 15;
    localparam int OPCODE_LO = 12;
    localparam int RS_HI     = 11;
    localparam int RS_LO     = 10;
    localparam int RT_HI     = 9;
    localparam int RT_LO     = 8;
    localparam int RD_HI     = 7;
    localparam int RD_LO     = 6;
    localparam int FUNCT_HI  = 5;
    localparam int FUNCT_LO  = 0;
    localparam int IMM_HI    = 7;
    localparam int IMM_LO    = 0;

    localparam opcode_t OP_BNE   = 4'd0;
    localparam opcode_t OP_BEQ   = 4'd1;
    localparam opcode_t OP_ADI   = 4'd4;
    localparam opcode_t OP_LHI   = 4'd6;
    localparam opcode_t OP_LWD   = 4'd7;
    localparam opcode_t OP_SWD   = 4'd8;
    localparam opcode_t OP_RTYPE = 4'd15;

    localparam funct_t FN_ADD = 6'd0;
    localparam funct_t FN_SUB = 6'd1;
    localparam funct_t FN_AND = 6'd2;
    localparam funct_t FN_ORR = 6'd3;
    localparam funct_t FN_WWD = 6'd28;
    localparam funct_t FN_HLT = 6'd29;

    // R-type with an unused funct, so it decodes to nothing
    localparam word_t NOP_WORD = 16'hF03F;

endpackage

// File: rtl/alu.sv
`timescale 1ns/1ps

module alu (
    input  cpu_pkg::word_t   a,
    input  cpu_pkg::word_t   b,
    input  cpu_pkg::alu_op_t op,
    output cpu_pkg::word_t   result
);
    import cpu_pkg::*;

    always_comb begin
        case (op)
            ALU_ADD: result = a + b;
            ALU_SUB: result = a - b;
            ALU_AND: result = a & b;
            ALU_OR:  result = a | b;
            // Immediate byte into the upper half
            ALU_LHI: result = {b[7:0], 8'h00};
            default: result = b;
        endcase
    end

endmodule

// File: rtl/control_unit.sv
`timescale 1ns/1ps

module control_unit (
    input  cpu_pkg::word_t    instr,
    output logic              alu_src,
    output logic              mem_read,
    output logic              mem_write,
    output logic              mem_to_reg,
    output logic              reg_write,
    output cpu_pkg::reg_idx_t write_dest,
    output cpu_pkg::alu_op_t  alu_op,
    output logic              is_branch,
    output logic              branch_on_equal,
    output logic              wwd,
    output logic              halt,
    output logic              uses_rt
);
    import cpu_pkg::*;

    opcode_t opcode;
    funct_t  funct;

    assign opcode = instr[OPCODE_HI:OPCODE_LO];
    assign funct  = instr[FUNCT_HI:FUNCT_LO];

    always_comb begin
        alu_src         = 1'b0;
        mem_read        = 1'b0;
        mem_write       = 1'b0;
        mem_to_reg      = 1'b0;
        reg_write       = 1'b0;
        write_dest      = instr[RD_HI:RD_LO];
        alu_op          = ALU_PASS_B;
        is_branch       = 1'b0;
        branch_on_equal = 1'b0;
        wwd             = 1'b0;
        halt            = 1'b0;
        uses_rt         = 1'b0;

        case (opcode)
            OP_RTYPE: begin
                case (funct)
                    FN_ADD: begin
                        reg_write = 1'b1;
                        uses_rt   = 1'b1;
                        alu_op    = ALU_ADD;
                    end
                    FN_SUB: begin
                        reg_write = 1'b1;
                        uses_rt   = 1'b1;
                        alu_op    = ALU_SUB;
                    end
                    FN_AND: begin
                        reg_write = 1'b1;
                        uses_rt   = 1'b1;
                        alu_op    = ALU_AND;
                    end
                    FN_ORR: begin
                        reg_write = 1'b1;
                        uses_rt   = 1'b1;
                        alu_op    = ALU_OR;
                    end
                    FN_WWD:  wwd  = 1'b1;
                    FN_HLT:  halt = 1'b1;
                    default: ;
                endcase
            end
            // I-type writes go to rt
            OP_ADI, OP_LHI, OP_LWD: begin
                alu_src    = 1'b1;
                reg_write  = 1'b1;
                write_dest = instr[RT_HI:RT_LO];
                alu_op     = (opcode == OP_LHI) ? ALU_LHI : ALU_ADD;
                mem_read   = (opcode == OP_LWD);
                mem_to_reg = (opcode == OP_LWD);
            end
            OP_SWD: begin
                alu_src   = 1'b1;
                mem_write = 1'b1;
                uses_rt   = 1'b1;
                alu_op    = ALU_ADD;
            end
            OP_BNE, OP_BEQ: begin
                is_branch       = 1'b1;
                branch_on_equal = (opcode == OP_BEQ);
                uses_rt         = 1'b1;
            end
            default: ;
        endcase
    end

endmodule

// File: rtl/register_file.sv
`timescale 1ns/1ps

module register_file #(
    parameter int WORD_BITS = 16,
    parameter int NUM_REGS  = 4
) (
    input  logic              clk,
    input  logic              reset_n,
    input  cpu_pkg::reg_idx_t read_idx1,
    input  cpu_pkg::reg_idx_t read_idx2,
    input  cpu_pkg::reg_idx_t write_idx,
    input  cpu_pkg::word_t    write_data,
    input  logic              write_en,
    output cpu_pkg::word_t    read_data1,
    output cpu_pkg::word_t    read_data2
);

    logic [WORD_BITS-1:0] regs [NUM_REGS];

    always_ff @(posedge clk) begin
        if (reset_n) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (write_en) begin
            regs[write_idx] <= write_data;
        end
    end

    // Write-through so decode sees the value retiring this cycle
    assign read_data1 = (write_en && write_idx == read_idx1) ? write_data : regs[read_idx1];
    assign read_data2 = (write_en && write_idx == read_idx2) ? write_data : regs[read_idx2];

endmodule

// File: rtl/hazard_unit.sv
`timescale 1ns/1ps

module hazard_unit (
    input  cpu_pkg::reg_idx_t id_rs,
    input  cpu_pkg::reg_idx_t id_rt,
    input  logic              id_uses_rt,
    input  logic              id_is_branch,
    input  cpu_pkg::reg_idx_t ex_dest,
    input  logic              ex_reg_write,
    input  logic              ex_mem_read,
    input  cpu_pkg::reg_idx_t ex_rs,
    input  cpu_pkg::reg_idx_t ex_rt,
    input  cpu_pkg::reg_idx_t mem_dest,
    input  logic              mem_reg_write,
    input  cpu_pkg::reg_idx_t wb_dest,
    input  logic              wb_reg_write,
    output logic              stall,
    output cpu_pkg::fwd_sel_t forward_a,
    output cpu_pkg::fwd_sel_t forward_b
);
    import cpu_pkg::*;

    logic ex_hits;
    logic mem_hits;
    logic load_use;
    logic branch_wait;

    // Decode sources about to be written by a younger stage
    assign ex_hits  = ex_reg_write &&
                      (ex_dest == id_rs || (id_uses_rt && ex_dest == id_rt));
    assign mem_hits = mem_reg_write &&
                      (mem_dest == id_rs || (id_uses_rt && mem_dest == id_rt));

    assign load_use    = ex_mem_read && ex_hits;
    // Branch compares in decode, so it has to wait for both stages
    assign branch_wait = id_is_branch && (ex_hits || mem_hits);
    assign stall       = load_use || branch_wait;

    // Memory stage wins over write-back
    function automatic fwd_sel_t pick_source(input reg_idx_t src);
        if (mem_reg_write && mem_dest == src) begin
            return FWD_FROM_MEM;
        end else if (wb_reg_write && wb_dest == src) begin
            return FWD_FROM_WB;
        end
        return FWD_NONE;
    endfunction

    always_comb begin
        forward_a = pick_source(ex_rs);
        forward_b = pick_source(ex_rt);
    end

endmodule

// File: rtl/cpu.sv
`timescale 1ns/1ps

module cpu #(
    parameter int WORD_BITS = 16
) (
    input  logic           clk,
    input  logic           reset_n,
    output logic           read_m1,
    output cpu_pkg::word_t address1,
    input  cpu_pkg::word_t data1,
    output logic           read_m2,
    output logic           write_m2,
    output cpu_pkg::word_t address2,
    output cpu_pkg::word_t write_data2,
    input  cpu_pkg::word_t read_data2,
    output cpu_pkg::word_t output_port,
    output logic           output_strobe,
    output cpu_pkg::word_t num_inst,
    output logic           is_halted
);
    import cpu_pkg::*;

    word_t    pc;
    logic     fetch_stopped;
    word_t    if_id_instr;
    word_t    if_id_pc;

    logic     id_alu_src;
    logic     id_mem_read;
    logic     id_mem_write;
    logic     id_mem_to_reg;
    logic     id_reg_write;
    reg_idx_t id_dest;
    alu_op_t  id_alu_op;
    logic     id_is_branch;
    logic     id_branch_on_equal;
    logic     id_wwd;
    logic     id_halt;
    logic     id_uses_rt;
    word_t    id_rs_data;
    word_t    id_rt_data;
    word_t    id_imm;
    word_t    branch_target;
    logic     branch_taken;
    logic     stall;

    logic     id_ex_valid;
    logic     id_ex_mem_read;
    logic     id_ex_mem_write;
    logic     id_ex_reg_write;
    logic     id_ex_wwd;
    logic     id_ex_halt;
    logic     id_ex_alu_src;
    logic     id_ex_mem_to_reg;
    alu_op_t  id_ex_alu_op;
    reg_idx_t id_ex_dest;
    reg_idx_t id_ex_rs;
    reg_idx_t id_ex_rt;
    word_t    id_ex_rs_data;
    word_t    id_ex_rt_data;
    word_t    id_ex_imm;

    fwd_sel_t forward_a;
    fwd_sel_t forward_b;
    word_t    ex_op_a;
    word_t    ex_rt_value;
    word_t    ex_result;
    word_t    ex_side;

    logic     ex_mem_valid;
    logic     ex_mem_mem_read;
    logic     ex_mem_mem_write;
    logic     ex_mem_reg_write;
    logic     ex_mem_wwd;
    logic     ex_mem_halt;
    logic     ex_mem_mem_to_reg;
    reg_idx_t ex_mem_dest;
    word_t    ex_mem_alu_out;
    word_t    ex_mem_side;

    logic     mem_wb_reg_write;
    logic     mem_wb_wwd;
    logic     mem_wb_mem_to_reg;
    reg_idx_t mem_wb_dest;
    word_t    mem_wb_alu_out;
    word_t    mem_wb_load_data;
    word_t    wb_data;

    //////////////////////////////////////////////////
    // Fetch
    //////////////////////////////////////////////////

    // Fetch stops for good once HLT leaves decode
    assign read_m1  = !(fetch_stopped || id_halt);
    assign address1 = pc;

    always_ff @(posedge clk) begin
        if (reset_n) begin
            pc            <= '0;
            fetch_stopped <= 1'b0;
            if_id_instr   <= NOP_WORD;
        end else if (!stall) begin
            if (branch_taken) begin
                pc <= branch_target;
            end else if (read_m1) begin
                pc <= pc + 16'd1;
            end
            if (id_halt) begin
                fetch_stopped <= 1'b1;
            end
            // Wrong-path fetch behind a taken branch becomes a bubble
            if_id_instr <= (branch_taken || !read_m1) ? NOP_WORD : data1;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            if_id_pc <= pc;
        end
    end

    //////////////////////////////////////////////////
    // Decode
    //////////////////////////////////////////////////

    control_unit u_control (
        .instr           (if_id_instr),
        .alu_src         (id_alu_src),
        .mem_read        (id_mem_read),
        .mem_write       (id_mem_write),
        .mem_to_reg      (id_mem_to_reg),
        .reg_write       (id_reg_write),
        .write_dest      (id_dest),
        .alu_op          (id_alu_op),
        .is_branch       (id_is_branch),
        .branch_on_equal (id_branch_on_equal),
        .wwd             (id_wwd),
        .halt            (id_halt),
        .uses_rt         (id_uses_rt)
    );

    register_file #(
        .WORD_BITS (WORD_BITS),
        .NUM_REGS  (4)
    ) u_regs (
        .clk        (clk),
        .reset_n    (reset_n),
        .read_idx1  (if_id_instr[RS_HI:RS_LO]),
        .read_idx2  (if_id_instr[RT_HI:RT_LO]),
        .write_idx  (mem_wb_dest),
        .write_data (wb_data),
        .write_en   (mem_wb_reg_write),
        .read_data1 (id_rs_data),
        .read_data2 (id_rt_data)
    );

    hazard_unit u_hazard (
        .id_rs         (if_id_instr[RS_HI:RS_LO]),
        .id_rt         (if_id_instr[RT_HI:RT_LO]),
        .id_uses_rt    (id_uses_rt),
        .id_is_branch  (id_is_branch),
        .ex_dest       (id_ex_dest),
        .ex_reg_write  (id_ex_reg_write),
        .ex_mem_read   (id_ex_mem_read),
        .ex_rs         (id_ex_rs),
        .ex_rt         (id_ex_rt),
        .mem_dest      (ex_mem_dest),
        .mem_reg_write (ex_mem_reg_write),
        .wb_dest       (mem_wb_dest),
        .wb_reg_write  (mem_wb_reg_write),
        .stall         (stall),
        .forward_a     (forward_a),
        .forward_b     (forward_b)
    );

    assign id_imm        = {{8{if_id_instr[IMM_HI]}}, if_id_instr[IMM_HI:IMM_LO]};
    assign branch_target = if_id_pc + 16'd1 + id_imm;
    assign branch_taken  = id_is_branch && !stall &&
                           ((id_rs_data == id_rt_data) == id_branch_on_equal);

    always_ff @(posedge clk) begin
        if (reset_n || stall) begin
            id_ex_valid     <= 1'b0;
            id_ex_mem_read  <= 1'b0;
            id_ex_mem_write <= 1'b0;
            id_ex_reg_write <= 1'b0;
            id_ex_wwd       <= 1'b0;
            id_ex_halt      <= 1'b0;
        end else begin
            id_ex_valid     <= (if_id_instr != NOP_WORD);
            id_ex_mem_read  <= id_mem_read;
            id_ex_mem_write <= id_mem_write;
            id_ex_reg_write <= id_reg_write;
            id_ex_wwd       <= id_wwd;
            id_ex_halt      <= id_halt;
        end
    end

    always_ff @(posedge clk) begin
        id_ex_alu_src    <= id_alu_src;
        id_ex_mem_to_reg <= id_mem_to_reg;
        id_ex_alu_op     <= id_alu_op;
        id_ex_dest       <= id_dest;
        id_ex_rs         <= if_id_instr[RS_HI:RS_LO];
        id_ex_rt         <= if_id_instr[RT_HI:RT_LO];
        id_ex_rs_data    <= id_rs_data;
        id_ex_rt_data    <= id_rt_data;
        id_ex_imm        <= id_imm;
    end

    //////////////////////////////////////////////////
    // Execute
    //////////////////////////////////////////////////

    function automatic word_t select_operand(input fwd_sel_t sel, input word_t reg_value);
        case (sel)
            FWD_FROM_MEM: return ex_mem_alu_out;
            FWD_FROM_WB:  return wb_data;
            default:      return reg_value;
        endcase
    endfunction

    always_comb begin
        ex_op_a     = select_operand(forward_a, id_ex_rs_data);
        ex_rt_value = select_operand(forward_b, id_ex_rt_data);
    end

    alu u_alu (
        .a      (ex_op_a),
        .b      (id_ex_alu_src ? id_ex_imm : ex_rt_value),
        .op     (id_ex_alu_op),
        .result (ex_result)
    );

    // Store data for SWD, the rs value for WWD
    assign ex_side = id_ex_wwd ? ex_op_a : ex_rt_value;

    always_ff @(posedge clk) begin
        if (reset_n) begin
            ex_mem_valid     <= 1'b0;
            ex_mem_mem_read  <= 1'b0;
            ex_mem_mem_write <= 1'b0;
            ex_mem_reg_write <= 1'b0;
            ex_mem_wwd       <= 1'b0;
            ex_mem_halt      <= 1'b0;
        end else begin
            ex_mem_valid     <= id_ex_valid;
            ex_mem_mem_read  <= id_ex_mem_read;
            ex_mem_mem_write <= id_ex_mem_write;
            ex_mem_reg_write <= id_ex_reg_write;
            ex_mem_wwd       <= id_ex_wwd;
            ex_mem_halt      <= id_ex_halt;
        end
    end

    always_ff @(posedge clk) begin
        ex_mem_mem_to_reg <= id_ex_mem_to_reg;
        ex_mem_dest       <= id_ex_dest;
        ex_mem_alu_out    <= ex_result;
        ex_mem_side       <= ex_side;
    end

    //////////////////////////////////////////////////
    // Memory and write-back
    //////////////////////////////////////////////////

    assign read_m2     = ex_mem_mem_read;
    assign write_m2    = ex_mem_mem_write;
    assign address2    = ex_mem_alu_out;
    assign write_data2 = ex_mem_side;

    always_ff @(posedge clk) begin
        if (reset_n) begin
            mem_wb_reg_write <= 1'b0;
            mem_wb_wwd       <= 1'b0;
            is_halted        <= 1'b0;
            num_inst         <= '0;
            output_port      <= '0;
        end else begin
            mem_wb_reg_write <= ex_mem_reg_write;
            mem_wb_wwd       <= ex_mem_wwd;
            is_halted        <= is_halted || ex_mem_halt;
            // Counted as it enters write-back
            if (ex_mem_valid) begin
                num_inst <= num_inst + 16'd1;
            end
            if (ex_mem_wwd) begin
                output_port <= ex_mem_side;
            end
        end
    end

    always_ff @(posedge clk) begin
        mem_wb_mem_to_reg <= ex_mem_mem_to_reg;
        mem_wb_dest       <= ex_mem_dest;
        mem_wb_alu_out    <= ex_mem_alu_out;
        mem_wb_load_data  <= read_data2;
    end

    assign wb_data       = mem_wb_mem_to_reg ? mem_wb_load_data : mem_wb_alu_out;
    assign output_strobe = mem_wb_wwd;

    assert property (@(posedge clk) disable iff (reset_n) !(read_m2 && write_m2))
        else $error("data port read and write at once");

    assert property (@(posedge clk) disable iff (reset_n) is_halted |-> !read_m1)
        else $error("fetch still active after the CPU halted");

endmodule

// File: sim/mem_model.sv
`timescale 1ns/1ps

module mem_model #(
    parameter int WORDS = 256
) (
    input  logic           clk,
    input  logic           read_m1,
    input  cpu_pkg::word_t address1,
    output cpu_pkg::word_t data1,
    input  logic           read_m2,
    input  logic           write_m2,
    input  cpu_pkg::word_t address2,
    input  cpu_pkg::word_t write_data2,
    output cpu_pkg::word_t read_data2
);
    import cpu_pkg::*;

    localparam int ADDR_BITS = $clog2(WORDS);

    word_t                mem [WORDS];
    logic [ADDR_BITS-1:0] fetch_addr;
    logic [ADDR_BITS-1:0] data_addr;

    assign fetch_addr = address1[ADDR_BITS-1:0];
    assign data_addr  = address2[ADDR_BITS-1:0];

    // Both ports read without a clock
    assign data1      = read_m1 ? mem[fetch_addr] : '0;
    assign read_data2 = read_m2 ? mem[data_addr] : '0;

    always @(posedge clk) begin
        if (write_m2) begin
            mem[data_addr] <= write_data2;
        end
    end

    task clear_all;
        for (int i = 0; i < WORDS; i++) begin
            mem[i] <= '0;
        end
    endtask

    task load_word(input word_t addr, input word_t value);
        mem[addr[ADDR_BITS-1:0]] <= value;
    endtask

endmodule

// File: sim/cpu_tb.sv
`timescale 1ns/1ps

module cpu_tb;
    import cpu_pkg::*;

    localparam int    CLK_PERIOD   = 40;
    localparam int    RESET_CYCLES = 8;
    localparam int    MEM_WORDS    = 256;
    localparam int    AFTER_HALT   = 5;
    localparam string VECTOR_FILE  = "sim/program_vectors.txt";

    logic  clk;
    logic  reset_n;
    logic  read_m1;
    word_t address1;
    word_t data1;
    logic  read_m2;
    logic  write_m2;
    word_t address2;
    word_t write_data2;
    word_t read_data2;
    word_t output_port;
    logic  output_strobe;
    word_t num_inst;
    logic  is_halted;

    word_t expected_out [$];
    word_t expected_count = '0;
    logic  count_seen     = 1'b0;
    int    image_lines    = 0;
    int    out_index      = 0;
    int    cycle_count    = 0;
    int    timeout_limit  = 0;
    int    mismatch_count = 0;
    int    failure_count  = 0;

    cpu #(
        .WORD_BITS (16)
    ) UUT (
        .clk           (clk),
        .reset_n       (reset_n),
        .read_m1       (read_m1),
        .address1      (address1),
        .data1         (data1),
        .read_m2       (read_m2),
        .write_m2      (write_m2),
        .address2      (address2),
        .write_data2   (write_data2),
        .read_data2    (read_data2),
        .output_port   (output_port),
        .output_strobe (output_strobe),
        .num_inst      (num_inst),
        .is_halted     (is_halted)
    );

    mem_model #(
        .WORDS (MEM_WORDS)
    ) u_mem (
        .clk         (clk),
        .read_m1     (read_m1),
        .address1    (address1),
        .data1       (data1),
        .read_m2     (read_m2),
        .write_m2    (write_m2),
        .address2    (address2),
        .write_data2 (write_data2),
        .read_data2  (read_data2)
    );

    //////////////////////////////////////////////////
    // Reporting
    //////////////////////////////////////////////////

    task automatic check_value(input string name, input word_t expected, input word_t actual);
        if (expected !== actual) begin
            $display("error %s: expected %h, actual %h", name, expected, actual);
            mismatch_count++;
        end
    endtask

    task automatic note_failure(input string msg);
        $display("%s", msg);
        failure_count++;
    endtask

    task automatic finish_run;
        $display("%0d value mismatches, %0d other failures", mismatch_count, failure_count);
        if (mismatch_count == 0 && failure_count == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    endtask

    //////////////////////////////////////////////////
    // Vector file
    //////////////////////////////////////////////////

    task automatic read_vectors;
        int         fd;
        string      line;
        string      fields;
        logic [7:0] kind;
        word_t      addr;
        word_t      value;
        fd = $fopen(VECTOR_FILE, "r");
        if (fd == 0) begin
            $display("cannot open the vector file %s", VECTOR_FILE);
        end else begin
            u_mem.clear_all();
            while ($fgets(line, fd) != 0) begin
                kind   = line.getc(0);
                fields = line.substr(1, line.len() - 1);
                if (kind == "M") begin
                    if ($sscanf(fields, "%h %h", addr, value) == 2) begin
                        u_mem.load_word(addr, value);
                        image_lines++;
                    end else begin
                        note_failure({"bad memory line in vector file: ", line});
                    end
                end else if (kind == "O") begin
                    if ($sscanf(fields, "%h", value) == 1) begin
                        expected_out.push_back(value);
                    end else begin
                        note_failure({"bad output line in vector file: ", line});
                    end
                end else if (kind == "N") begin
                    if ($sscanf(fields, "%h", value) == 1) begin
                        expected_count = value;
                        count_seen     = 1'b1;
                    end else begin
                        note_failure({"bad count line in vector file: ", line});
                    end
                end
            end
            $fclose(fd);
        end
        timeout_limit = 4 * image_lines + 100;
    endtask

    //////////////////////////////////////////////////
    // Clock, timeout and output monitor
    //////////////////////////////////////////////////

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count++;
        if (timeout_limit > 0 && cycle_count >= timeout_limit) begin
            note_failure($sformatf("timeout: the CPU did not halt within %0d cycles",
                                   timeout_limit));
            finish_run();
        end
    end

    // Outputs settle by the falling edge
    always @(negedge clk) begin
        if (!reset_n && output_strobe) begin
            if (is_halted) begin
                note_failure("output strobe seen after the CPU halted");
            end else if (out_index < expected_out.size()) begin
                check_value($sformatf("output word %0d", out_index),
                            expected_out[out_index], output_port);
                out_index++;
            end else begin
                note_failure($sformatf("unexpected extra output strobe with value %h",
                                       output_port));
            end
        end
    end

    //////////////////////////////////////////////////
    // Main sequence
    //////////////////////////////////////////////////

    initial begin
        reset_n = 1'b1;
        read_vectors();
        if (image_lines == 0 || expected_out.size() == 0 || !count_seen) begin
            note_failure("the vector file is missing or lacks program, outputs or count");
            finish_run();
        end else begin
            repeat (RESET_CYCLES) @(posedge clk);
            @(negedge clk);
            reset_n = 1'b0;

            while (!is_halted) begin
                @(negedge clk);
            end

            // Pipeline must stay quiet after halt
            repeat (AFTER_HALT) @(negedge clk);

            check_value("instruction count", expected_count, num_inst);
            if (out_index != expected_out.size()) begin
                note_failure($sformatf("only %0d of %0d expected output words were written",
                                       out_index, expected_out.size()));
            end
            finish_run();
        end
    end

endmodule

// File: sim/program_vectors.txt
# M addr word: memory image in hex; O word: expected output_port per strobe, in order
# N count: expected final num_inst in hex; text after the fields is ignored
M 00 4105  ADI r1, r0, 5
M 01 6212  LHI r2, 0x12
M 02 F6C0  ADD r3, r1, r2   forwarded from memory and write-back
M 03 FC1C  WWD r3
M 04 F9C1  SUB r3, r2, r1
M 05 F41C  WWD r1
M 06 FC1C  WWD r3           distance two
M 07 FE02  AND r0, r3, r2
M 08 F103  ORR r0, r0, r1
M 09 F01C  WWD r0
M 0A 8740  SWD r3 to r1 + 0x40
M 0B 7640  LWD r2 from r1 + 0x40
M 0C F980  ADD r2, r2, r1   load-use stall
M 0D F81C  WWD r2
M 0E 1501  BEQ r1, r1, +1   taken
M 0F F41C  WWD r1           skipped
M 10 0601  BNE r1, r2, +1   taken
M 11 F41C  WWD r1           skipped
M 12 1601  BEQ r1, r2, +1   not taken
M 13 FC1C  WWD r3
M 14 45FF  ADI r1, r1, -1
M 15 0501  BNE r1, r1, +1   stalls, not taken
M 16 F41C  WWD r1
M 17 F01D  HLT
M 18 F01C  WWD r0           never fetched
O 1205
O 0005
O 11FB
O 1005
O 1200
O 11FB
O 0004
N 0016

// File: project.f
rtl/cpu_pkg.sv
rtl/alu.sv
rtl/control_unit.sv
rtl/register_file.sv
rtl/hazard_unit.sv
rtl/cpu.sv
sim/mem_model.sv
sim/cpu_tb.sv

// File: run.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --assert --timescale 1ns/1ps -j 0 \
    --top-module cpu_tb -f project.f -o cpu_tb_sim

output="$(./obj_dir/cpu_tb_sim)"
echo "$output"

if grep -qx "Done: no errors" <<< "$output"; then
    exit 0
fi
exit 1
